// File: design/calc_pkg.sv
`default_nettype none

package calc_pkg;

    localparam int CALC_W = 16;                 // Operand and result width
    localparam int CNT_W  = $clog2(CALC_W);     // Bit counter width in both units

    // Keypad operator codes
    typedef enum logic [1:0] {
        OP_ADD = 2'b00,                         // Sum
        OP_SUB = 2'b01,                         // First minus second, wraps
        OP_MUL = 2'b11                          // Product, low word kept
    } calc_op_t;

    // Controller sequence
    typedef enum logic [2:0] {
        GET_FIRST  = 3'b000,                    // Collecting first operand
        GET_SECOND = 3'b001,                    // Collecting second operand
        DISPATCH   = 3'b010,                    // Raise start next cycle
        WAIT_UNIT  = 3'b011,                    // Unit busy
        SHOW       = 3'b100                     // Result latched, complete high
    } calc_state_t;

    // Controller to arithmetic unit
    typedef struct packed {
        logic              start;               // One-cycle launch
        logic [CALC_W-1:0] a;                   // First operand
        logic [CALC_W-1:0] b;                   // Second operand
        logic              sub;                 // Adder only, multiplier ignores
    } unit_req_t;

    // Arithmetic unit back to controller
    typedef struct packed {
        logic              finish;              // One-cycle done pulse
        logic [CALC_W-1:0] value;               // Valid while finish high
    } unit_res_t;

endpackage

`default_nettype wire

// File: design/calc_control.sv
`timescale 1ns/1ns
`default_nettype none

module calc_control import calc_pkg::*; (
    input  logic              clk,
    input  logic              nRST,
    input  logic [3:0]        digit,        // Decimal key value
    input  logic              digit_valid,  // One strobe per digit key
    input  calc_op_t          op,           // Operator key value
    input  logic              op_valid,     // One strobe per operator key
    input  logic              equal,        // Equal key strobe
    input  unit_res_t         add_res,      // From serial adder
    input  unit_res_t         mul_res,      // From multiplier
    output unit_req_t         add_req,      // To serial adder
    output unit_req_t         mul_req,      // To multiplier
    output logic              ready,        // Keys honoured only while high
    output logic              complete,     // One-cycle done flag
    output logic [CALC_W-1:0] display       // Last result
);

    calc_state_t       state;               // Current FSM state
    calc_state_t       next_state;
    logic [CALC_W-1:0] opnd_a;              // First operand accumulator
    logic [CALC_W-1:0] opnd_b;              // Second operand accumulator
    calc_op_t          opcode;              // Latched operator
    logic              use_mul;             // Multiplier selected
    logic              start_q;             // Registered launch pulse
    logic              unit_finish;         // Finish of the selected unit
    logic [CALC_W-1:0] unit_value;          // Result of the selected unit

    // New value is old times ten plus digit, mod 2^CALC_W
    function automatic logic [CALC_W-1:0] append_digit(
        input logic [CALC_W-1:0] cur,
        input logic [3:0]        d
    );
        logic [CALC_W-1:0] times8;
        logic [CALC_W-1:0] times2;
        times8 = cur << 3;
        times2 = cur << 1;
        return times8 + times2 + {{(CALC_W-4){1'b0}}, d};
    endfunction

    assign ready    = (state == GET_FIRST) || (state == GET_SECOND);
    assign complete = (state == SHOW);
    assign use_mul  = (opcode == OP_MUL);

    // Listen only to the unit that was started
    assign unit_finish = use_mul ? mul_res.finish : add_res.finish;
    assign unit_value  = use_mul ? mul_res.value  : add_res.value;

    // Both requests share operands, only one start fires
    assign add_req.start = start_q & ~use_mul;
    assign add_req.a     = opnd_a;
    assign add_req.b     = opnd_b;
    assign add_req.sub   = (opcode == OP_SUB);

    assign mul_req.start = start_q & use_mul;
    assign mul_req.a     = opnd_a;
    assign mul_req.b     = opnd_b;
    assign mul_req.sub   = 1'b0;            // Unused by multiplier

    always_comb begin
        next_state = state;                 // Hold by default
        case (state)
            GET_FIRST: begin
                if (op_valid)
                    next_state = GET_SECOND;  // Operator ends first operand
            end
            GET_SECOND: begin
                if (equal)
                    next_state = DISPATCH;
            end
            DISPATCH:  next_state = WAIT_UNIT;
            WAIT_UNIT: begin
                if (unit_finish)
                    next_state = SHOW;
            end
            SHOW:      next_state = GET_FIRST;
            default:   next_state = GET_FIRST;
        endcase
    end

    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            state <= GET_FIRST;
        end else begin
            state <= next_state;
        end
    end

    // Operand entry and opcode latch
    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            opnd_a <= '0;
            opnd_b <= '0;
            opcode <= OP_ADD;
        end else begin
            case (state)
                GET_FIRST: begin
                    if (digit_valid)
                        opnd_a <= append_digit(opnd_a, digit);
                    if (op_valid)
                        opcode <= op;       // Later operators ignored
                end
                GET_SECOND: begin
                    if (digit_valid)
                        opnd_b <= append_digit(opnd_b, digit);
                end
                SHOW: begin
                    opnd_a <= '0;           // Fresh entry on return to GET_FIRST
                    opnd_b <= '0;
                end
                default: ;                  // Operands stay stable for the unit
            endcase
        end
    end

    // Start one cycle after DISPATCH, result latch at finish
    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            start_q <= 1'b0;
            display <= '0;
        end else begin
            start_q <= (state == DISPATCH);
            if ((state == WAIT_UNIT) && unit_finish)
                display <= unit_value;      // Held until next result
        end
    end

endmodule

`default_nettype wire

// File: design/serial_add_sub.sv
`timescale 1ns/1ns
`default_nettype none

module serial_add_sub import calc_pkg::*; (
    input  logic      clk,
    input  logic      nRST,
    input  unit_req_t req,                  // Operands and start
    output unit_res_t res                   // Sum and finish
);

    logic [CALC_W-1:0] a_sr;                // First operand, shifts right
    logic [CALC_W-1:0] b_sr;                // Second operand, inverted for subtract
    logic [CALC_W-1:0] sum_sr;              // Result bits fill from the top
    logic              carry;               // Ripple carry between cycles
    logic              busy;
    logic              finish_q;
    logic [CNT_W-1:0]  bit_cnt;             // Bit position being added
    logic              sum_bit;
    logic              carry_next;
    logic              last_bit;

    // Full adder on the low bits
    assign sum_bit    = a_sr[0] ^ b_sr[0] ^ carry;
    assign carry_next = (a_sr[0] & b_sr[0]) | (carry & (a_sr[0] ^ b_sr[0]));
    assign last_bit   = (bit_cnt == CNT_W'(CALC_W - 1));

    assign res.finish = finish_q;
    assign res.value  = sum_sr;

    // Sequencing
    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            busy     <= 1'b0;
            finish_q <= 1'b0;
            bit_cnt  <= '0;
        end else begin
            finish_q <= busy & last_bit;    // Pulse after the top bit
            if (busy) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (last_bit)
                    busy <= 1'b0;
            end else if (req.start) begin
                busy    <= 1'b1;            // Start ignored while busy
                bit_cnt <= '0;
            end
        end
    end

    // Bit-serial datapath, LSB first
    always_ff @(posedge clk) begin
        if (busy) begin
            a_sr   <= a_sr >> 1;
            b_sr   <= b_sr >> 1;
            carry  <= carry_next;
            sum_sr <= {sum_bit, sum_sr[CALC_W-1:1]};
        end else if (req.start) begin
            a_sr  <= req.a;
            b_sr  <= req.sub ? ~req.b : req.b;  // Two's complement via inversion
            carry <= req.sub;               // Plus one for subtract
        end
    end

endmodule

`default_nettype wire

// File: design/shift_add_mult.sv
`timescale 1ns/1ns
`default_nettype none

module shift_add_mult import calc_pkg::*; (
    input  logic      clk,
    input  logic      nRST,
    input  unit_req_t req,                  // Operands and start, sub ignored
    output unit_res_t res                   // Product and finish
);

    logic [CALC_W-1:0] acc;                 // Partial product, low word only
    logic [CALC_W-1:0] mcand;               // Multiplicand, shifts left
    logic [CALC_W-1:0] mplier;              // Multiplier, shifts right
    logic              busy;
    logic              finish_q;
    logic [CNT_W-1:0]  step_cnt;            // Multiplier bit being used
    logic              last_step;
    logic [CALC_W-1:0] acc_next;

    assign last_step = (step_cnt == CNT_W'(CALC_W - 1));

    // Add shifted multiplicand when the current multiplier bit is set
    assign acc_next = mplier[0] ? acc + mcand : acc;

    assign res.finish = finish_q;
    assign res.value  = acc;

    // Sequencing
    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            busy     <= 1'b0;
            finish_q <= 1'b0;
            step_cnt <= '0;
        end else begin
            finish_q <= busy & last_step;   // Pulse after the final add
            if (busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (last_step)
                    busy <= 1'b0;
            end else if (req.start) begin
                busy     <= 1'b1;           // Start ignored while busy
                step_cnt <= '0;
            end
        end
    end

    // Shift-add datapath
    always_ff @(posedge clk) begin
        if (busy) begin
            acc    <= acc_next;             // Carries past the top bit drop off
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end else if (req.start) begin
            acc    <= '0;
            mcand  <= req.a;
            mplier <= req.b;
        end
    end

    // Product bits above CALC_W never matter since mcand
    // loses its high bits on each shift as well

endmodule

`default_nettype wire

// File: design/calc_top.sv
`timescale 1ns/1ns
`default_nettype none

module calc_top import calc_pkg::*; (
    input  logic              clk,
    input  logic              nRST,
    input  logic [3:0]        digit,        // Keypad digit
    input  logic              digit_valid,
    input  calc_op_t          op,           // Keypad operator
    input  logic              op_valid,
    input  logic              equal,
    output logic              ready,        // Keypad accepted
    output logic              complete,     // Result pulse
    output logic [CALC_W-1:0] display       // Result word
);

    unit_req_t add_req;                     // Controller to adder
    unit_req_t mul_req;                     // Controller to multiplier
    unit_res_t add_res;                     // Adder result
    unit_res_t mul_res;                     // Multiplier result

    calc_control u_control (
        .clk         (clk),
        .nRST        (nRST),
        .digit       (digit),
        .digit_valid (digit_valid),
        .op          (op),
        .op_valid    (op_valid),
        .equal       (equal),
        .add_res     (add_res),
        .mul_res     (mul_res),
        .add_req     (add_req),
        .mul_req     (mul_req),
        .ready       (ready),
        .complete    (complete),
        .display     (display)
    );

    serial_add_sub u_add_sub (              // Add and subtract
        .clk  (clk),
        .nRST (nRST),
        .req  (add_req),
        .res  (add_res)
    );

    shift_add_mult u_mult (                 // Multiply
        .clk  (clk),
        .nRST (nRST),
        .req  (mul_req),
        .res  (mul_res)
    );

endmodule

`default_nettype wire

// File: dv/calc_sva.sv
`timescale 1ns/1ns
`default_nettype none

module calc_sva import calc_pkg::*; (
    input logic        clk,
    input logic        nRST,
    input calc_state_t state,
    input logic        add_start,
    input logic        mul_start,
    input logic        ready,
    input logic        complete
);

    logic any_start;
    assign any_start = add_start | mul_start;

    // Single-cycle launch
    start_one_cycle: assert property (@(posedge clk) disable iff (nRST)
        any_start |=> !any_start)
        else $error("start held for two cycles");

    complete_in_show: assert property (@(posedge clk) disable iff (nRST)
        complete |-> (state == SHOW))
        else $error("complete high outside SHOW");

    ready_in_entry: assert property (@(posedge clk) disable iff (nRST)
        !(state inside {GET_FIRST, GET_SECOND}) |-> !ready)
        else $error("ready high outside entry states");

    // Quiet outputs during reset
    reset_outputs: assert property (@(posedge clk)
        nRST |-> (ready && !complete && !any_start))
        else $error("outputs wrong during reset");

endmodule

bind calc_control calc_sva u_sva (
    .clk       (clk),
    .nRST      (nRST),
    .state     (state),
    .add_start (add_req.start),
    .mul_start (mul_req.start),
    .ready     (ready),
    .complete  (complete)
);

`default_nettype wire

// File: dv/calc_tb.sv
`timescale 1ns/1ns
`default_nettype none

module calc_tb import calc_pkg::*; ();

    localparam int NUM_TESTS   = 40;
    localparam int IDLE_MAX    = 2;                          // Idle cycles between keys
    localparam int LATENCY     = CALC_W + 3;                 // Equal edge to complete
    localparam int LAT_LIMIT   = 4 * LATENCY;                // Give up waiting for complete
    localparam int CYCLE_LIMIT = NUM_TESTS * (5 + 5 + 2 + IDLE_MAX) * 4 + LATENCY * NUM_TESTS;

    logic              clk;
    logic              nRST;
    logic [3:0]        digit;
    logic              digit_valid;
    calc_op_t          op;
    logic              op_valid;
    logic              equal;
    logic              ready;
    logic              complete;
    logic [CALC_W-1:0] display;

    logic [31:0]       rng_state;                            // LCG state
    int                errors;                               // Failed checks
    int                checks;
    int                cycle_cnt;
    logic [CALC_W-1:0] last_result;                          // Expected display contents

    calc_top uut (
        .clk         (clk),
        .nRST        (nRST),
        .digit       (digit),
        .digit_valid (digit_valid),
        .op          (op),
        .op_valid    (op_valid),
        .equal       (equal),
        .ready       (ready),
        .complete    (complete),
        .display     (display)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;                                   // 20 ns period

    // Run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = next_random();
        return int'(r[30:16]) % n;                           // Upper bits, better spread
    endfunction

    function automatic calc_op_t pick_op(input int k);
        case (k)
            0:       return OP_ADD;
            1:       return OP_SUB;
            default: return OP_MUL;
        endcase
    endfunction

    // Keypad entry rule, mod 2^16
    function automatic logic [CALC_W-1:0] times_ten_plus(
        input logic [CALC_W-1:0] cur,
        input logic [3:0]        d
    );
        logic [31:0] wide;
        wide = 32'(cur) * 32'd10 + 32'(d);
        return wide[CALC_W-1:0];
    endfunction

    task automatic check_word(input string name, input logic [CALC_W-1:0] expected,
                              input logic [CALC_W-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s expected %b actual %b", name, expected, actual);
        end
    endtask

    task automatic wait_ready();
        @(negedge clk);                                      // Outputs settled here
        while (!ready)
            @(negedge clk);
    endtask

    // One-cycle strobe, then random idle
    task automatic press_digit(input logic [3:0] d);
        int idle;
        idle = rand_below(IDLE_MAX + 1);
        wait_ready();
        @(posedge clk);
        digit       <= d;
        digit_valid <= 1'b1;
        @(posedge clk);
        digit_valid <= 1'b0;
        repeat (idle) @(posedge clk);
    endtask

    task automatic press_op(input calc_op_t o);
        int idle;
        idle = rand_below(IDLE_MAX + 1);
        wait_ready();
        @(posedge clk);
        op       <= o;
        op_valid <= 1'b1;
        @(posedge clk);
        op_valid <= 1'b0;
        repeat (idle) @(posedge clk);
    endtask

    task automatic run_calc(input int t);
        calc_op_t          cur_op;
        int                na;
        int                nb;
        int                lat;
        int                err_before;
        logic              zero_b;
        logic [3:0]        d;
        logic [CALC_W-1:0] ma;
        logic [CALC_W-1:0] mb;
        logic [CALC_W-1:0] expected;
        logic [31:0]       prod;
        err_before = errors;
        cur_op     = pick_op(rand_below(3));
        na         = 1 + rand_below(5);
        nb         = 1 + rand_below(5);
        zero_b     = (t % 10 == 4);
        if (zero_b) begin
            cur_op = OP_MUL;                                 // Product with zero
            nb     = 1;
        end
        if (t % 10 == 7) begin
            cur_op = OP_SUB;                                 // Short minus long, wraps
            na     = 1;
            nb     = 5;
        end
        ma = '0;
        mb = '0;
        for (int i = 0; i < na; i++) begin
            d  = 4'(rand_below(10));
            ma = times_ten_plus(ma, d);
            press_digit(d);
        end
        press_op(cur_op);
        for (int i = 0; i < nb; i++) begin
            d  = zero_b ? 4'd0 : 4'(rand_below(10));
            mb = times_ten_plus(mb, d);
            press_digit(d);
            if (i == 0)
                press_op(pick_op(rand_below(3)));            // Ignored in GET_SECOND
        end
        case (cur_op)
            OP_ADD:  expected = ma + mb;
            OP_SUB:  expected = ma - mb;
            default: begin
                prod     = 32'(ma) * 32'(mb);
                expected = prod[CALC_W-1:0];                 // Low word only
            end
        endcase

        wait_ready();
        check_word("display held before equal", last_result, display);
        @(posedge clk);
        equal <= 1'b1;
        @(posedge clk);                                      // Equal sampled here
        equal       <= 1'b0;
        digit       <= 4'(rand_below(10));                   // Keys from DISPATCH on
        digit_valid <= 1'b1;
        op          <= pick_op(rand_below(3));
        op_valid    <= 1'b1;
        lat = 0;
        @(negedge clk);
        while (!complete && lat < LAT_LIMIT) begin
            @(posedge clk);
            lat++;
            if (lat <= 10) begin
                digit       <= 4'(rand_below(10));           // Keys while busy
                digit_valid <= 1'b1;
                op          <= pick_op(rand_below(3));
                op_valid    <= (lat % 2 == 1);
            end else begin
                digit_valid <= 1'b0;
                op_valid    <= 1'b0;
            end
            @(negedge clk);
        end
        if (!complete) begin
            errors++;
            $display("complete never rose within %0d cycles of equal", LAT_LIMIT);
        end else begin
            check_word("complete latency", CALC_W'(LATENCY), CALC_W'(lat));
            check_word("display result", expected, display);
        end
        @(posedge clk);
        digit_valid <= 1'b0;
        op_valid    <= 1'b0;
        @(negedge clk);
        check_flag("complete one cycle", 1'b0, complete);
        check_word("display held after complete", expected, display);
        last_result = expected;
        $display("test %0d: %0d %s %0d = %0d, %s", t, ma, cur_op.name(), mb, expected,
                 (errors == err_before) ? "pass" : "fail");
    endtask

    initial begin
        rng_state   = 32'd68265;
        errors      = 0;
        checks      = 0;
        cycle_cnt   = 0;
        last_result = '0;
        nRST        <= 1'b1;                                 // Reset held from time zero
        digit       <= 4'd0;
        digit_valid <= 1'b0;
        op          <= OP_ADD;
        op_valid    <= 1'b0;
        equal       <= 1'b0;
        repeat (8) @(posedge clk);
        nRST <= 1'b0;
        @(negedge clk);
        check_word("display after reset", '0, display);
        check_flag("complete after reset", 1'b0, complete);
        check_flag("ready after reset", 1'b1, ready);
        $display("test reset: %s", (errors == 0) ? "pass" : "fail");
        for (int t = 0; t < NUM_TESTS; t++)
            run_calc(t);
        $display("%0d calculations, %0d checks, %0d failed checks", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: calc_top.f
design/calc_pkg.sv
design/calc_control.sv
design/serial_add_sub.sv
design/shift_add_mult.sv
design/calc_top.sv
dv/calc_sva.sv
dv/calc_tb.sv

// File: Makefile
SRCS = $(shell grep -v '^+' calc_top.f)

.PHONY: all run clean

all: run

obj_dir/Vcalc_tb: calc_top.f $(SRCS)
	verilator --binary --timing --assert --top-module calc_tb -f calc_top.f

run: obj_dir/Vcalc_tb
	@out="$$(./obj_dir/Vcalc_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir
